//--- hdl/emu_pkg.sv
package emu_pkg;

    // Widths of the host register space
    typedef logic [11:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [63:0] tick_cnt_t;

    // Register map, byte offsets
    localparam addr_t MODE_CTRL   = 12'h000;
    localparam addr_t STEP_CNT    = 12'h004;
    localparam addr_t TICK_CNT_LO = 12'h008;
    localparam addr_t TICK_CNT_HI = 12'h00C;
    localparam addr_t SCAN_CTRL   = 12'h010;

    // Banked registers, four 32-bit words each (0x0 to 0xC)
    localparam addr_t TRIG_STAT   = 12'h100;
    localparam addr_t TRIG_EN     = 12'h110;
    localparam addr_t RESET_CTRL  = 12'h120;

    // Host request payload, held stable while host_req is high
    typedef struct packed {
        logic  wr;
        addr_t addr;
        data_t wdata;
    } host_req_t;

    // Single-cycle strobe bus into the register file
    typedef struct packed {
        logic  wen;
        logic  ren;
        addr_t addr;
        data_t wdata;
    } ctrl_bus_t;

    typedef enum logic [1:0] {
        idle,
        access,
        ack_hold
    } host_state_e;

endpackage

//--- hdl/host_port.sv
`timescale 1ns/10ps

module host_port (
    input  logic               host_clk,
    input  logic               host_rst,
    input  logic               host_req,
    input  emu_pkg::host_req_t host_cmd,
    input  emu_pkg::data_t     ctrl_rdata,
    output logic               host_ack,
    output emu_pkg::data_t     host_rdata,
    output emu_pkg::ctrl_bus_t ctrl_bus
);

    emu_pkg::host_state_e state;

    logic           wen_q;
    logic           ren_q;
    emu_pkg::addr_t addr_q;
    emu_pkg::data_t wdata_q;

    // Handshake FSM, one strobe per request
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            state    <= emu_pkg::idle;
            wen_q    <= 1'b0;
            ren_q    <= 1'b0;
            host_ack <= 1'b0;
        end else begin
            wen_q <= 1'b0;
            ren_q <= 1'b0;
            case (state)
                emu_pkg::idle: begin
                    if (host_req) begin
                        wen_q <= host_cmd.wr;
                        ren_q <= !host_cmd.wr;
                        state <= emu_pkg::access;
                    end
                end
                emu_pkg::access: begin
                    host_ack <= 1'b1;
                    state    <= emu_pkg::ack_hold;
                end
                emu_pkg::ack_hold: begin
                    // Host may hold req as long as it likes
                    if (!host_req) begin
                        host_ack <= 1'b0;
                        state    <= emu_pkg::idle;
                    end
                end
                default: state <= emu_pkg::idle;
            endcase
        end
    end

    // Request payload and returned read data
    always_ff @(posedge host_clk) begin
        if (state == emu_pkg::idle && host_req) begin
            addr_q  <= host_cmd.addr;
            wdata_q <= host_cmd.wdata;
        end
        // Sampled in the strobe cycle, held through the ack phase
        if (state == emu_pkg::access) begin
            host_rdata <= ctrl_rdata;
        end
    end

    assign ctrl_bus = '{wen: wen_q, ren: ren_q, addr: addr_q, wdata: wdata_q};

endmodule

//--- hdl/emu_ctrl_regs.sv
`timescale 1ns/10ps

module emu_ctrl_regs #(
    parameter int TRIG_COUNT  = 1,
    parameter int RESET_COUNT = 1
) (
    input  logic                   host_clk,
    input  logic                   host_rst,
    input  emu_pkg::ctrl_bus_t     ctrl_bus,
    input  logic                   tick,
    input  logic                   model_busy,
    input  logic [TRIG_COUNT-1:0]  trig,
    input  logic                   scan_running,
    output emu_pkg::data_t         ctrl_rdata,
    output logic                   run_mode,
    output logic                   scan_mode,
    output logic [RESET_COUNT-1:0] model_rst,
    output logic                   scan_start,
    output logic                   scan_dir
);

    // Replace one 32-bit word of a bank of up to 128 bits
    function automatic logic [127:0] word_merge(
        input logic [127:0]   cur,
        input logic [1:0]     sel,
        input emu_pkg::data_t wdata
    );
        logic [127:0] nxt;
        nxt = cur;
        nxt[sel*32 +: 32] = wdata;
        return nxt;
    endfunction

    function automatic emu_pkg::data_t word_pick(
        input logic [127:0] bank,
        input logic [1:0]   sel
    );
        return bank[sel*32 +: 32];
    endfunction

    emu_pkg::addr_t addr;
    logic [1:0]     word_sel;

    logic hit_mode;
    logic hit_step;
    logic hit_tick_lo;
    logic hit_tick_hi;
    logic hit_scan;
    logic hit_trig_stat;
    logic hit_trig_en;
    logic hit_reset;

    logic pause_pend;
    logic trig_active;
    logic step_last;
    logic stop_run;

    emu_pkg::data_t         step_cnt;
    emu_pkg::tick_cnt_t     tick_cnt;
    logic [TRIG_COUNT-1:0]  trig_stat;
    logic [TRIG_COUNT-1:0]  trig_en;

    assign addr     = ctrl_bus.addr;
    assign word_sel = addr[3:2];

    // Single registers decode on the word address, banks on the 16-byte block
    assign hit_mode      = addr[11:2] == emu_pkg::MODE_CTRL[11:2];
    assign hit_step      = addr[11:2] == emu_pkg::STEP_CNT[11:2];
    assign hit_tick_lo   = addr[11:2] == emu_pkg::TICK_CNT_LO[11:2];
    assign hit_tick_hi   = addr[11:2] == emu_pkg::TICK_CNT_HI[11:2];
    assign hit_scan      = addr[11:2] == emu_pkg::SCAN_CTRL[11:2];
    assign hit_trig_stat = addr[11:4] == emu_pkg::TRIG_STAT[11:4];
    assign hit_trig_en   = addr[11:4] == emu_pkg::TRIG_EN[11:4];
    assign hit_reset     = addr[11:4] == emu_pkg::RESET_CTRL[11:4];

    // Stop conditions, evaluated on a tick only
    assign step_last   = step_cnt == 32'd1;
    assign trig_active = |(trig_en & trig);
    assign stop_run    = run_mode && tick && (pause_pend || trig_active || step_last);

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            run_mode   <= 1'b0;
            pause_pend <= 1'b0;
        end else if (stop_run) begin
            run_mode   <= 1'b0;
            pause_pend <= 1'b0;
        end else if (ctrl_bus.wen && hit_mode) begin
            if (ctrl_bus.wdata[0]) begin
                run_mode   <= 1'b1;
                pause_pend <= 1'b0;
            end else if (run_mode) begin
                // Pause waits for the next tick boundary
                pause_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            scan_mode <= 1'b0;
        end else if (ctrl_bus.wen && hit_mode) begin
            scan_mode <= ctrl_bus.wdata[1];
        end
    end

    // Step limit, zero means free running
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            step_cnt <= '0;
        end else if (run_mode && tick) begin
            step_cnt <= (step_cnt == '0) ? '0 : step_cnt - 32'd1;
        end else if (!run_mode && ctrl_bus.wen && hit_step) begin
            step_cnt <= ctrl_bus.wdata;
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            tick_cnt <= '0;
        end else if (run_mode && tick) begin
            tick_cnt <= tick_cnt + 64'd1;
        end else if (!run_mode && ctrl_bus.wen) begin
            if (hit_tick_lo) begin
                tick_cnt[31:0] <= ctrl_bus.wdata;
            end
            if (hit_tick_hi) begin
                tick_cnt[63:32] <= ctrl_bus.wdata;
            end
        end
    end

    // Trigger snapshot, frozen while paused
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            trig_stat <= '0;
        end else if (run_mode) begin
            trig_stat <= trig;
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            trig_en <= '0;
        end else if (ctrl_bus.wen && hit_trig_en) begin
            trig_en <= TRIG_COUNT'(word_merge(128'(trig_en), word_sel, ctrl_bus.wdata));
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            model_rst <= '0;
        end else if (ctrl_bus.wen && hit_reset) begin
            model_rst <= RESET_COUNT'(word_merge(128'(model_rst), word_sel, ctrl_bus.wdata));
        end
    end

    // Direction is locked during a transfer
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            scan_dir <= 1'b0;
        end else if (ctrl_bus.wen && hit_scan && !scan_running) begin
            scan_dir <= ctrl_bus.wdata[1];
        end
    end

    assign scan_start = ctrl_bus.wen && hit_scan && ctrl_bus.wdata[0];

    // Read mux, valid during the read strobe
    always_comb begin
        ctrl_rdata = '0;
        if (ctrl_bus.ren) begin
            if (hit_mode) begin
                ctrl_rdata = {28'd0, model_busy, pause_pend, scan_mode, run_mode};
            end else if (hit_step) begin
                ctrl_rdata = step_cnt;
            end else if (hit_tick_lo) begin
                ctrl_rdata = tick_cnt[31:0];
            end else if (hit_tick_hi) begin
                ctrl_rdata = tick_cnt[63:32];
            end else if (hit_scan) begin
                ctrl_rdata = {30'd0, scan_dir, scan_running};
            end else if (hit_trig_stat) begin
                ctrl_rdata = word_pick(128'(trig_stat), word_sel);
            end else if (hit_trig_en) begin
                ctrl_rdata = word_pick(128'(trig_en), word_sel);
            end else if (hit_reset) begin
                ctrl_rdata = word_pick(128'(model_rst), word_sel);
            end
        end
    end

endmodule

//--- hdl/tick_gen.sv
`timescale 1ns/10ps

module tick_gen #(
    parameter int TICK_DIV = 4
) (
    input  logic host_clk,
    input  logic host_rst,
    input  logic run_mode,
    input  logic model_busy,
    output logic tick
);

    localparam int              CNT_W    = $clog2(TICK_DIV);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIV - 1);

    logic [CNT_W-1:0] div_cnt;

    // First pulse lands TICK_DIV cycles after run_mode rises
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (!run_mode) begin
            // Paused, restart from zero
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (model_busy) begin
            // Hold the phase while the model catches up
            tick <= 1'b0;
        end else if (div_cnt == CNT_LAST) begin
            div_cnt <= '0;
            tick    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

endmodule

//--- hdl/scan_engine.sv
`timescale 1ns/10ps

module scan_engine #(
    parameter int SCAN_LEN = 16
) (
    input  logic host_clk,
    input  logic host_rst,
    input  logic scan_start,
    input  logic scan_dir,
    input  logic scan_out,
    output logic scan_running,
    output logic scan_en,
    output logic scan_in
);

    localparam int               CNT_W    = (SCAN_LEN > 1) ? $clog2(SCAN_LEN) : 1;
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(SCAN_LEN - 1);

    logic [CNT_W-1:0] bit_cnt;

    // Transfer runs for exactly SCAN_LEN shift cycles
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            scan_running <= 1'b0;
            bit_cnt      <= '0;
        end else if (!scan_running) begin
            if (scan_start) begin
                scan_running <= 1'b1;
                bit_cnt      <= '0;
            end
        end else if (bit_cnt == BIT_LAST) begin
            scan_running <= 1'b0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Chain shifts only while the transfer is active
    assign scan_en = scan_running;

    // Rotate feeds the chain output back, clear shifts in zeros
    assign scan_in = scan_dir ? 1'b0 : scan_out;

endmodule

//--- hdl/emu_sys_top.sv
`timescale 1ns/10ps

module emu_sys_top #(
    parameter int TRIG_COUNT  = 1,
    parameter int RESET_COUNT = 1,
    parameter int TICK_DIV    = 4,
    parameter int SCAN_LEN    = 16
) (
    input  logic                   host_clk,
    input  logic                   host_rst,
    input  logic                   host_req,
    input  emu_pkg::host_req_t     host_cmd,
    output logic                   host_ack,
    output emu_pkg::data_t         host_rdata,
    input  logic                   model_busy,
    input  logic [TRIG_COUNT-1:0]  trig,
    input  logic                   scan_out,
    output logic                   model_tick,
    output logic                   run_mode,
    output logic                   scan_mode,
    output logic [RESET_COUNT-1:0] model_rst,
    output logic                   scan_en,
    output logic                   scan_in
);

    emu_pkg::ctrl_bus_t ctrl_bus;
    emu_pkg::data_t     ctrl_rdata;

    logic scan_start;
    logic scan_dir;
    logic scan_running;

    host_port u_host_port (
        .host_clk   (host_clk),
        .host_rst   (host_rst),
        .host_req   (host_req),
        .host_cmd   (host_cmd),
        .ctrl_rdata (ctrl_rdata),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .ctrl_bus   (ctrl_bus)
    );

    emu_ctrl_regs #(
        .TRIG_COUNT  (TRIG_COUNT),
        .RESET_COUNT (RESET_COUNT)
    ) u_ctrl_regs (
        .host_clk     (host_clk),
        .host_rst     (host_rst),
        .ctrl_bus     (ctrl_bus),
        .tick         (model_tick),
        .model_busy   (model_busy),
        .trig         (trig),
        .scan_running (scan_running),
        .ctrl_rdata   (ctrl_rdata),
        .run_mode     (run_mode),
        .scan_mode    (scan_mode),
        .model_rst    (model_rst),
        .scan_start   (scan_start),
        .scan_dir     (scan_dir)
    );

    // Tick drives the model directly
    tick_gen #(
        .TICK_DIV (TICK_DIV)
    ) u_tick_gen (
        .host_clk   (host_clk),
        .host_rst   (host_rst),
        .run_mode   (run_mode),
        .model_busy (model_busy),
        .tick       (model_tick)
    );

    scan_engine #(
        .SCAN_LEN (SCAN_LEN)
    ) u_scan_engine (
        .host_clk     (host_clk),
        .host_rst     (host_rst),
        .scan_start   (scan_start),
        .scan_dir     (scan_dir),
        .scan_out     (scan_out),
        .scan_running (scan_running),
        .scan_en      (scan_en),
        .scan_in      (scan_in)
    );

endmodule

//--- test/tb_emu_sys.sv
`timescale 1ns/10ps

module tb_emu_sys;

    localparam int TRIG_COUNT    = 40;
    localparam int RESET_COUNT   = 8;
    localparam int TICK_DIV      = 4;
    localparam int SCAN_LEN      = 16;
    localparam int CLK_PERIOD_NS = 10;
    // Budget of 500 cycles for all tests and a fourfold margin
    localparam int TEST_CYCLES   = 500;
    localparam int TIMEOUT_NS    = 4 * TEST_CYCLES * CLK_PERIOD_NS;

    logic                   host_clk;
    logic                   host_rst;
    logic                   host_req;
    emu_pkg::host_req_t     host_cmd;
    logic                   host_ack;
    emu_pkg::data_t         host_rdata;
    logic                   model_busy;
    logic [TRIG_COUNT-1:0]  trig;
    logic                   scan_out;
    logic                   model_tick;
    logic                   run_mode;
    logic                   scan_mode;
    logic [RESET_COUNT-1:0] model_rst;
    logic                   scan_en;
    logic                   scan_in;

    // Model stand-in scan chain
    logic [SCAN_LEN-1:0] chain = '0;
    logic [SCAN_LEN-1:0] chain_load_val;
    logic                chain_load;

    emu_pkg::data_t tick_total;
    emu_pkg::data_t scan_cycles;
    logic [31:0]    lcg_state;
    int             error_count;
    int             check_count;

    emu_sys_top #(
        .TRIG_COUNT  (TRIG_COUNT),
        .RESET_COUNT (RESET_COUNT),
        .TICK_DIV    (TICK_DIV),
        .SCAN_LEN    (SCAN_LEN)
    ) u_dut (
        .host_clk   (host_clk),
        .host_rst   (host_rst),
        .host_req   (host_req),
        .host_cmd   (host_cmd),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .model_busy (model_busy),
        .trig       (trig),
        .scan_out   (scan_out),
        .model_tick (model_tick),
        .run_mode   (run_mode),
        .scan_mode  (scan_mode),
        .model_rst  (model_rst),
        .scan_en    (scan_en),
        .scan_in    (scan_in)
    );

    initial host_clk = 1'b0;
    always #(CLK_PERIOD_NS / 2) host_clk = ~host_clk;

    // Chain shifts toward bit 0 while the DUT enables it
    always @(posedge host_clk) begin
        if (chain_load) begin
            chain <= chain_load_val;
        end else if (scan_en) begin
            chain <= {scan_in, chain[SCAN_LEN-1:1]};
        end
    end

    assign scan_out = chain[0];

    // Running totals of tick pulses and scan shift cycles
    always @(posedge host_clk) begin
        if (host_rst) begin
            tick_total  <= '0;
            scan_cycles <= '0;
        end else begin
            if (model_tick) begin
                tick_total <= tick_total + 32'd1;
            end
            if (scan_en) begin
                scan_cycles <= scan_cycles + 32'd1;
            end
        end
    end

    function automatic emu_pkg::data_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic next_cycle();
        @(posedge host_clk);
        #1;
    endtask

    task automatic check_data(input string name, input emu_pkg::data_t exp,
                              input emu_pkg::data_t act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("Error in %s: expected 0x%08h, actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic check_tick(input string name, input emu_pkg::tick_cnt_t exp,
                              input emu_pkg::tick_cnt_t act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("Error in %s: expected 0x%016h, actual 0x%016h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("Error in %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Full four-phase handshake with req held until ack
    task automatic host_access(input logic wr, input emu_pkg::addr_t addr,
                               input emu_pkg::data_t wdata, output emu_pkg::data_t rdata);
        host_cmd.wr    = wr;
        host_cmd.addr  = addr;
        host_cmd.wdata = wdata;
        host_req       = 1'b1;
        while (!host_ack) begin
            next_cycle();
        end
        rdata    = host_rdata;
        host_req = 1'b0;
        while (host_ack) begin
            next_cycle();
        end
    endtask

    task automatic host_write(input emu_pkg::addr_t addr, input emu_pkg::data_t wdata);
        emu_pkg::data_t unused;
        host_access(1'b1, addr, wdata, unused);
    endtask

    task automatic host_read(input emu_pkg::addr_t addr, output emu_pkg::data_t rdata);
        host_access(1'b0, addr, 32'd0, rdata);
    endtask

    task automatic load_chain(input logic [SCAN_LEN-1:0] value);
        chain_load_val = value;
        chain_load     = 1'b1;
        next_cycle();
        chain_load     = 1'b0;
    endtask

    task automatic register_readback();
        emu_pkg::data_t step_v;
        emu_pkg::data_t lo_v;
        emu_pkg::data_t hi_v;
        emu_pkg::data_t en0_v;
        emu_pkg::data_t en1_v;
        emu_pkg::data_t rst_v;
        emu_pkg::data_t lo_rd;
        emu_pkg::data_t hi_rd;
        emu_pkg::data_t rd;
        step_v = next_random();
        lo_v   = next_random();
        hi_v   = next_random();
        en0_v  = next_random();
        en1_v  = next_random();
        rst_v  = next_random();
        host_write(emu_pkg::STEP_CNT, step_v);
        host_write(emu_pkg::TICK_CNT_LO, lo_v);
        host_write(emu_pkg::TICK_CNT_HI, hi_v);
        host_write(emu_pkg::TRIG_EN, en0_v);
        host_write(emu_pkg::TRIG_EN + 12'h004, en1_v);
        host_write(emu_pkg::RESET_CTRL, rst_v);

        host_read(emu_pkg::STEP_CNT, rd);
        check_data("register_readback STEP_CNT", step_v, rd);
        host_read(emu_pkg::TICK_CNT_LO, lo_rd);
        host_read(emu_pkg::TICK_CNT_HI, hi_rd);
        check_tick("register_readback TICK_CNT", {hi_v, lo_v}, {hi_rd, lo_rd});
        host_read(emu_pkg::TRIG_EN, rd);
        check_data("register_readback TRIG_EN word 0", en0_v, rd);
        // Only triggers 39:32 exist in word 1
        host_read(emu_pkg::TRIG_EN + 12'h004, rd);
        check_data("register_readback TRIG_EN word 1", {24'd0, en1_v[7:0]}, rd);
        host_read(emu_pkg::RESET_CTRL, rd);
        check_data("register_readback RESET_CTRL", {24'd0, rst_v[7:0]}, rd);
        check_data("register_readback model_rst", {24'd0, rst_v[7:0]}, {24'd0, model_rst});

        host_write(emu_pkg::MODE_CTRL, 32'h0000_0002);
        check_bit("register_readback scan_mode set", 1'b1, scan_mode);
        host_read(emu_pkg::MODE_CTRL, rd);
        check_data("register_readback MODE_CTRL scan bit", 32'h0000_0002, rd);
        host_write(emu_pkg::MODE_CTRL, 32'h0000_0000);
        check_bit("register_readback scan_mode clear", 1'b0, scan_mode);
    endtask

    task automatic step_run();
        emu_pkg::data_t start;
        emu_pkg::data_t lo_rd;
        emu_pkg::data_t hi_rd;
        emu_pkg::data_t rd;
        host_write(emu_pkg::STEP_CNT, 32'd5);
        host_write(emu_pkg::TICK_CNT_LO, 32'd0);
        host_write(emu_pkg::TICK_CNT_HI, 32'd0);
        start = tick_total;
        host_write(emu_pkg::MODE_CTRL, 32'h0000_0001);
        check_bit("step_run run_mode after start", 1'b1, run_mode);
        while (run_mode) begin
            next_cycle();
        end
        check_data("step_run tick pulses", 32'd5, tick_total - start);
        host_read(emu_pkg::TICK_CNT_LO, lo_rd);
        host_read(emu_pkg::TICK_CNT_HI, hi_rd);
        check_tick("step_run TICK_CNT", 64'd5, {hi_rd, lo_rd});
        host_read(emu_pkg::STEP_CNT, rd);
        check_data("step_run STEP_CNT", 32'd0, rd);
    endtask

    task automatic pause_busy_stall();
        emu_pkg::data_t start;
        emu_pkg::data_t rd;
        host_write(emu_pkg::STEP_CNT, 32'd0);
        model_busy = 1'b1;
        start = tick_total;
        host_write(emu_pkg::MODE_CTRL, 32'h0000_0001);
        repeat (5 * TICK_DIV) begin
            next_cycle();
        end
        check_data("pause_busy ticks while busy", start, tick_total);
        // Bits are run, scan, pause pending, busy
        host_read(emu_pkg::MODE_CTRL, rd);
        check_data("pause_busy MODE_CTRL busy", 32'h0000_0009, rd);
        host_write(emu_pkg::MODE_CTRL, 32'h0000_0000);
        host_read(emu_pkg::MODE_CTRL, rd);
        check_data("pause_busy MODE_CTRL pending", 32'h0000_000D, rd);

        // Divider still at zero so the read lands before the next tick
        model_busy = 1'b0;
        host_read(emu_pkg::MODE_CTRL, rd);
        check_data("pause_busy MODE_CTRL released", 32'h0000_0005, rd);
        while (run_mode) begin
            next_cycle();
        end
        check_data("pause_busy ticks until pause", 32'd1, tick_total - start);
        host_read(emu_pkg::MODE_CTRL, rd);
        check_data("pause_busy MODE_CTRL paused", 32'h0000_0000, rd);
    endtask

    task automatic trigger_stop();
        emu_pkg::data_t start;
        emu_pkg::data_t rd;
        int             wait_cycles;
        host_write(emu_pkg::TRIG_EN, 32'd0);
        host_write(emu_pkg::TRIG_EN + 12'h004, 32'h0000_0008);
        host_write(emu_pkg::STEP_CNT, 32'd0);
        // Trigger 10 is disabled and must not stop the run
        trig[10] = 1'b1;
        host_write(emu_pkg::MODE_CTRL, 32'h0000_0001);
        start = tick_total;
        while (run_mode && tick_total - start < 32'd3) begin
            next_cycle();
        end
        check_bit("trigger_stop run_mode with disabled trigger", 1'b1, run_mode);

        trig[35] = 1'b1;
        wait_cycles = 0;
        while (run_mode && wait_cycles <= TICK_DIV) begin
            next_cycle();
            wait_cycles++;
        end
        check_count++;
        if (run_mode) begin
            error_count++;
            $display("trigger_stop: run_mode stayed high past the next tick after trigger 35");
        end
        host_read(emu_pkg::TRIG_STAT, rd);
        check_data("trigger_stop TRIG_STAT word 0", 32'h0000_0400, rd);
        host_read(emu_pkg::TRIG_STAT + 12'h004, rd);
        check_data("trigger_stop TRIG_STAT word 1", 32'h0000_0008, rd);
        trig = '0;
    endtask

    task automatic scan_transfer();
        emu_pkg::data_t      rnd;
        emu_pkg::data_t      start;
        emu_pkg::data_t      rd;
        logic [SCAN_LEN-1:0] pattern;
        rnd     = next_random();
        pattern = rnd[SCAN_LEN-1:0];
        load_chain(pattern);

        // Rotate pass
        start = scan_cycles;
        host_write(emu_pkg::SCAN_CTRL, 32'h0000_0001);
        check_bit("scan_transfer scan_en after start", 1'b1, scan_en);
        host_read(emu_pkg::SCAN_CTRL, rd);
        check_data("scan_transfer SCAN_CTRL running", 32'h0000_0001, rd);
        host_write(emu_pkg::SCAN_CTRL, 32'h0000_0002);
        host_read(emu_pkg::SCAN_CTRL, rd);
        check_data("scan_transfer SCAN_CTRL dir locked", 32'h0000_0001, rd);
        while (scan_en) begin
            next_cycle();
        end
        check_data("scan_transfer rotate cycles", SCAN_LEN, scan_cycles - start);
        check_data("scan_transfer rotate chain", {16'd0, pattern}, {16'd0, chain});
        host_read(emu_pkg::SCAN_CTRL, rd);
        check_data("scan_transfer SCAN_CTRL idle", 32'h0000_0000, rd);

        // Clear pass
        start = scan_cycles;
        host_write(emu_pkg::SCAN_CTRL, 32'h0000_0003);
        while (scan_en) begin
            next_cycle();
        end
        check_data("scan_transfer clear cycles", SCAN_LEN, scan_cycles - start);
        check_data("scan_transfer clear chain", 32'd0, {16'd0, chain});
        host_read(emu_pkg::SCAN_CTRL, rd);
        check_data("scan_transfer SCAN_CTRL clear dir", 32'h0000_0002, rd);
    endtask

    initial begin
        host_rst       = 1'b1;
        host_req       = 1'b0;
        host_cmd       = '0;
        model_busy     = 1'b0;
        trig           = '0;
        chain_load     = 1'b0;
        chain_load_val = '0;
        lcg_state      = 32'h05ea_9783;
        error_count    = 0;
        check_count    = 0;
        repeat (3) begin
            @(posedge host_clk);
        end
        #1;
        host_rst = 1'b0;

        register_readback();
        step_run();
        pause_busy_stall();
        trigger_stop();
        scan_transfer();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: tests still running after %0d ns", TIMEOUT_NS);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- src.f
hdl/emu_pkg.sv
hdl/host_port.sv
hdl/emu_ctrl_regs.sv
hdl/tick_gen.sv
hdl/scan_engine.sv
hdl/emu_sys_top.sv
test/tb_emu_sys.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the emulator control testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_emu_sys
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module "$TOP" -f src.f -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification passed" "$LOG"; then
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1
